// ==== Bender.yml ====
package:
  name: lsu_top

sources:
  - hdl/lsu_pkg.sv
  - hdl/lsu_load.sv
  - hdl/lsu_store.sv
  - hdl/axi_lite_ram.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - dv/lsu_top_tb.sv

// ==== dv/lsu_top_tb.sv ====
`default_nettype none

module lsu_top_tb;
  import lsu_pkg::*;

  localparam int mem_words = 256;
  localparam int timeout_cycles = 2000;

  logic            clk;
  logic            rstn;
  logic            rreq_valid, rreq_ready, rres_valid, rres_ready;
  logic            wreq_valid, wreq_ready, wres_valid, wres_ready;
  logic            mem_hold;
  logic [XLEN-1:0] raddr, rdata, waddr, wdata;
  load_func_e      rfunc;
  store_func_e     wfunc;

  // byte-wide reference memory
  logic [7:0]      model_mem [mem_words*4];
  logic [31:0]     exp_q [$];
  logic [31:0]     exp_word;
  logic [31:0]     lfsr;
  logic            stall_heavy;
  int              errors, timeouts, tests_failed;
  int              loads_issued, loads_done, stores_issued, stores_done;

  lsu_top dut_i (
    .clk        (clk),
    .rstn       (rstn),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .raddr      (raddr),
    .rfunc      (rfunc),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .rdata      (rdata),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .waddr      (waddr),
    .wfunc      (wfunc),
    .wdata      (wdata),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready),
    .mem_hold   (mem_hold)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [2:0] pick_load_func();
    logic [2:0] f;
    do begin
      f = take_bits(3);
    end while (f == 3'd3 || f[2:1] == 2'b11);
    return f;
  endfunction

  function automatic int access_bytes(input logic [1:0] size);
    return (size == 2'd0) ? 1 : (size == 2'd1) ? 2 : 4;
  endfunction

  function automatic logic [31:0] expect_load(input logic [9:0] addr, input logic [2:0] func);
    int          nbytes;
    logic [31:0] val;
    nbytes = access_bytes(func[1:0]);
    val = '0;
    for (int k = 0; k < nbytes; k++) begin
      // lanes past the word end read as zero
      if (addr[1:0] + k < 4) begin
        val[8*k +: 8] = model_mem[addr + k];
      end
    end
    if (!func[2] && nbytes < 4 && val[8*nbytes-1]) begin
      val = val | (32'hFFFF_FFFF << (8*nbytes));
    end
    return val;
  endfunction

  task automatic store_model(input logic [9:0] addr, input logic [2:0] func,
                             input logic [31:0] data);
    for (int k = 0; k < access_bytes(func[1:0]); k++) begin
      if (addr[1:0] + k < 4) begin
        model_mem[addr + k] = data[8*k +: 8];
      end
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic next_cycle();
    @(negedge clk);
    mem_hold   = (take_bits(2) == 0);
    rres_ready = stall_heavy ? (take_bits(2) == 0) : (take_bits(2) != 0);
    wres_ready = stall_heavy ? (take_bits(2) == 0) : (take_bits(2) != 0);
  endtask

  // offer a load, a store or both and hold each until accepted
  task automatic send_pair(input logic do_ld, input logic [9:0] la, input logic [2:0] lf,
                           input logic do_st, input logic [9:0] sa, input logic [2:0] sf,
                           input logic [31:0] sd);
    logic ld_pend, st_pend, ld_fire, st_fire;
    int   t;
    ld_pend = do_ld;
    st_pend = do_st;
    t = 0;
    rreq_valid = do_ld;
    raddr = {22'd0, la};
    rfunc = load_func_e'(lf);
    wreq_valid = do_st;
    waddr = {22'd0, sa};
    wfunc = store_func_e'(sf);
    wdata = sd;
    while ((ld_pend || st_pend) && t < timeout_cycles) begin
      ld_fire = ld_pend && rreq_ready;
      st_fire = st_pend && wreq_ready;
      if (ld_fire) begin
        exp_q.push_back(expect_load(la, lf));
        loads_issued++;
      end
      if (st_fire) begin
        store_model(sa, sf, sd);
        stores_issued++;
      end
      next_cycle();
      t++;
      if (ld_fire) begin
        ld_pend = 1'b0;
        rreq_valid = 1'b0;
      end
      if (st_fire) begin
        st_pend = 1'b0;
        wreq_valid = 1'b0;
      end
    end
    assert (!ld_pend && !st_pend) else begin
      $display("timeout: request was never accepted by the DUT");
      timeouts++;
    end
  endtask

  task automatic drain();
    int t;
    t = 0;
    while ((exp_q.size() != 0 || stores_done != stores_issued) && t < timeout_cycles) begin
      next_cycle();
      t++;
    end
    assert (exp_q.size() == 0 && stores_done == stores_issued) else begin
      $display("timeout: outstanding responses never returned");
      timeouts++;
    end
  endtask

  task automatic read_words(input int first, input int last);
    for (int w = first; w < last; w++) begin
      send_pair(1'b1, 10'(w*4), 3'd2, 1'b0, '0, '0, '0);
    end
    drain();
  endtask

  task automatic report_test(input int num, input string name, input int mark);
    if (errors + timeouts == mark) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: failed", num, name);
      tests_failed++;
    end
  endtask

  // responses are matched in order against the queue
  always @(posedge clk) begin
    if (!rstn) begin
      if (rres_valid && rres_ready) begin
        loads_done++;
        assert (exp_q.size() != 0) else begin
          $display("load response arrived with no load outstanding");
          errors++;
        end
        if (exp_q.size() != 0) begin
          exp_word = exp_q.pop_front();
          check_value("rdata", rdata, exp_word);
        end
      end
      if (wres_valid && wres_ready) begin
        stores_done++;
        assert (stores_done <= stores_issued) else begin
          $display("store response arrived with no store outstanding");
          errors++;
        end
      end
    end
  end

  initial begin
    logic [9:0]  la, sa;
    logic [2:0]  lf, sf;
    logic [31:0] sd;
    int          mark;
    lfsr = 32'd81860;
    stall_heavy = 1'b0;
    errors = 0;
    timeouts = 0;
    tests_failed = 0;
    loads_issued = 0;
    loads_done = 0;
    stores_issued = 0;
    stores_done = 0;
    rstn = 1'b1;
    rreq_valid = 1'b0;
    raddr = '0;
    rfunc = ld_w;
    rres_ready = 1'b0;
    wreq_valid = 1'b0;
    waddr = '0;
    wfunc = st_w;
    wdata = '0;
    wres_ready = 1'b0;
    mem_hold = 1'b0;
    repeat (2) @(negedge clk);
    rstn = 1'b0;

    mark = errors + timeouts;
    check_value("rreq_ready", rreq_ready, 1);
    check_value("wreq_ready", wreq_ready, 1);
    check_value("rres_valid", rres_valid, 0);
    check_value("wres_valid", wres_valid, 0);
    report_test(1, "reset state", mark);

    mark = errors + timeouts;
    for (int w = 0; w < mem_words; w++) begin
      sd = take_bits(32);
      send_pair(1'b0, '0, '0, 1'b1, 10'(w*4), 3'd2, sd);
    end
    drain();
    check_value("stores_done", stores_done, mem_words);
    report_test(2, "word fill", mark);

    mark = errors + timeouts;
    for (int i = 0; i < 200; i++) begin
      la = take_bits(10);
      lf = pick_load_func();
      send_pair(1'b1, la, lf, 1'b0, '0, '0, '0);
    end
    drain();
    report_test(3, "random loads", mark);

    mark = errors + timeouts;
    for (int i = 0; i < 100; i++) begin
      sa = take_bits(10);
      sf = take_bits(1);
      sd = take_bits(32);
      send_pair(1'b0, '0, '0, 1'b1, sa, sf, sd);
    end
    drain();
    read_words(0, mem_words);
    report_test(4, "byte and half stores", mark);

    // heavy response back-pressure
    mark = errors + timeouts;
    stall_heavy = 1'b1;
    for (int i = 0; i < 64; i++) begin
      sa = take_bits(10);
      sf = take_bits(2);
      sf = (sf == 3'd3) ? 3'd2 : sf;
      sd = take_bits(32);
      send_pair(1'b0, '0, '0, 1'b1, sa, sf, sd);
    end
    drain();
    for (int i = 0; i < 64; i++) begin
      la = take_bits(10);
      lf = pick_load_func();
      send_pair(1'b1, la, lf, 1'b0, '0, '0, '0);
    end
    drain();
    stall_heavy = 1'b0;
    check_value("loads_done", loads_done, loads_issued);
    check_value("stores_done", stores_done, stores_issued);
    report_test(5, "back-to-back", mark);

    // loads in the low half and stores in the high half
    mark = errors + timeouts;
    for (int i = 0; i < 128; i++) begin
      la = {1'b0, 9'(take_bits(9))};
      lf = pick_load_func();
      sa = {1'b1, 9'(take_bits(9))};
      sf = take_bits(2);
      sf = (sf == 3'd3) ? 3'd2 : sf;
      sd = take_bits(32);
      send_pair(1'b1, la, lf, 1'b1, sa, sf, sd);
    end
    drain();
    read_words(mem_words / 2, mem_words);
    check_value("loads_done", loads_done, loads_issued);
    report_test(6, "concurrent loads and stores", mark);

    $display("tests run 6, failed %0d, errors %0d, timeouts %0d, loads %0d, stores %0d",
             tests_failed, errors, timeouts, loads_done, stores_done);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/axi_lite_ram.sv ====
`default_nettype none

module axi_lite_ram #(
  parameter int mem_words = 256
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       mem_hold,
  input  logic [lsu_pkg::XLEN-1:0]   araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [lsu_pkg::XLEN-1:0]   rdata,
  output logic                       rvalid,
  input  logic                       rready,
  input  logic [lsu_pkg::XLEN-1:0]   awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [lsu_pkg::XLEN-1:0]   wdata,
  input  logic [lsu_pkg::STRB_W-1:0] wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  output logic                       bvalid,
  input  logic                       bready
);
  import lsu_pkg::*;

  localparam int idx_w = $clog2(mem_words);

  logic [XLEN-1:0]   mem [mem_words];

  logic              ar_pend;
  logic [idx_w-1:0]  ar_idx;

  logic              aw_pend;
  logic [idx_w-1:0]  aw_idx;
  logic              w_pend;
  logic [XLEN-1:0]   w_data;
  logic [STRB_W-1:0] w_strb;

  logic              commit;

  // a single read beat outstanding at a time
  assign arready = ~mem_hold & ~ar_pend & (~rvalid | rready);
  assign awready = ~mem_hold & ~aw_pend;
  assign wready  = ~mem_hold & ~w_pend;

  // address and data both in, B slot free
  assign commit = aw_pend & w_pend & ~mem_hold & (~bvalid | bready);

  always_ff @(posedge clk) begin
    if (rstn) begin
      ar_pend <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (arvalid && arready) begin
        ar_pend <= 1'b1;
        ar_idx  <= araddr[idx_w+1:2];
      end else if (ar_pend && !mem_hold) begin
        ar_pend <= 1'b0;
        rvalid  <= 1'b1;
        rdata   <= mem[ar_idx];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (awvalid && awready) begin
        aw_pend <= 1'b1;
        aw_idx  <= awaddr[idx_w+1:2];
      end
      if (wvalid && wready) begin
        w_pend <= 1'b1;
        w_data <= wdata;
        w_strb <= wstrb;
      end
      if (commit) begin
        aw_pend <= 1'b0;
        w_pend  <= 1'b0;
        bvalid  <= 1'b1;
      end
    end
  end

  // byte-masked word write
  always_ff @(posedge clk) begin
    if (commit) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (w_strb[i]) begin
          mem[aw_idx][8*i +: 8] <= w_data[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_load.sv ====
`default_nettype none

module lsu_load (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic [lsu_pkg::XLEN-1:0] raddr,
  input  lsu_pkg::load_func_e      rfunc,
  input  logic                     rreq_valid,
  output logic                     rreq_ready,
  output logic [lsu_pkg::XLEN-1:0] rdata,
  output logic                     rres_valid,
  input  logic                     rres_ready,
  output logic [lsu_pkg::XLEN-1:0] araddr,
  output logic                     arvalid,
  input  logic                     arready,
  input  logic [lsu_pkg::XLEN-1:0] bus_rdata,
  input  logic                     rvalid,
  output logic                     rready
);
  import lsu_pkg::*;

  // request parked while the AR slot is busy
  logic [XLEN-1:0]  skid_addr;
  load_func_e       skid_func;

  // side queue, entry 0 follows AR, entry 1 follows the R beat
  logic [OFF_W-1:0] q_off  [2];
  load_func_e       q_func [2];

  logic [XLEN-1:0]  rdata_hold;
  logic [XLEN-1:0]  beat_shifted;
  logic [XLEN-1:0]  beat_word;

  logic             req_fire;
  logic             ar_fire;
  logic             r_fire;
  logic             ar_free;
  logic             res_free;

  assign req_fire = rreq_valid & rreq_ready;
  assign ar_fire  = arvalid & arready;
  assign r_fire   = rvalid & rready;
  assign ar_free  = ~arvalid | arready;
  assign res_free = ~rres_valid | rres_ready;

  // addressed byte down to lane 0
  assign beat_shifted = bus_rdata >> {q_off[1], 3'b000};

  always_comb begin
    case (q_func[1])
      ld_b:    beat_word = {{(XLEN-8){beat_shifted[7]}}, beat_shifted[7:0]};
      ld_bu:   beat_word = {{(XLEN-8){1'b0}}, beat_shifted[7:0]};
      ld_h:    beat_word = {{(XLEN-16){beat_shifted[15]}}, beat_shifted[15:0]};
      ld_hu:   beat_word = {{(XLEN-16){1'b0}}, beat_shifted[15:0]};
      default: beat_word = beat_shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      rreq_ready <= 1'b1;
      arvalid    <= 1'b0;
      rready     <= 1'b1;
      rres_valid <= 1'b0;
    end else begin
      // address accepted, offset and function move on with it
      if (ar_fire) begin
        arvalid   <= 1'b0;
        q_off[1]  <= q_off[0];
        q_func[1] <= q_func[0];
      end

      if (req_fire) begin
        if (ar_free) begin
          arvalid   <= 1'b1;
          araddr    <= raddr;
          q_off[0]  <= raddr[OFF_W-1:0];
          q_func[0] <= rfunc;
        end else begin
          rreq_ready <= 1'b0;
          skid_addr  <= raddr;
          skid_func  <= rfunc;
        end
      end

      // skid drains once AR is free again
      if (!rreq_ready && ar_free) begin
        arvalid    <= 1'b1;
        araddr     <= skid_addr;
        q_off[0]   <= skid_addr[OFF_W-1:0];
        q_func[0]  <= skid_func;
        rreq_ready <= 1'b1;
      end

      if (rres_valid && rres_ready) begin
        rres_valid <= 1'b0;
      end

      if (r_fire) begin
        if (res_free) begin
          rres_valid <= 1'b1;
          rdata      <= beat_word;
        end else begin
          // output still taken, park the beat and stall R
          rdata_hold <= beat_word;
          rready     <= 1'b0;
        end
      end

      if (!rready && res_free) begin
        rres_valid <= 1'b1;
        rdata      <= rdata_hold;
        rready     <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

  // data and address width
  localparam int XLEN = 32;

  // one strobe per byte lane
  localparam int STRB_W = XLEN / 8;

  // byte offset inside a word
  localparam int OFF_W = $clog2(STRB_W);

  // funct3 encodings of the load instructions
  typedef enum logic [2:0] {
    ld_b  = 3'd0,
    ld_h  = 3'd1,
    ld_w  = 3'd2,
    ld_bu = 3'd4,
    ld_hu = 3'd5
  } load_func_e;

  // funct3 encodings of the store instructions
  typedef enum logic [2:0] {
    st_b = 3'd0,
    st_h = 3'd1,
    st_w = 3'd2
  } store_func_e;

endpackage

`default_nettype wire

// ==== hdl/lsu_store.sv ====
`default_nettype none

module lsu_store (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic [lsu_pkg::XLEN-1:0]   waddr,
  input  logic [lsu_pkg::XLEN-1:0]   wdata,
  input  lsu_pkg::store_func_e       wfunc,
  input  logic                       wreq_valid,
  output logic                       wreq_ready,
  output logic                       wres_valid,
  input  logic                       wres_ready,
  output logic [lsu_pkg::XLEN-1:0]   awaddr,
  output logic                       awvalid,
  input  logic                       awready,
  output logic [lsu_pkg::XLEN-1:0]   wdata_bus,
  output logic [lsu_pkg::STRB_W-1:0] wstrb,
  output logic                       wvalid,
  input  logic                       wready,
  input  logic                       bvalid,
  output logic                       bready
);
  import lsu_pkg::*;

  logic [STRB_W-1:0] strb_base;
  logic [STRB_W-1:0] strb_lane;
  logic [XLEN-1:0]   data_lane;

  // one skid per channel, AW and W drain on their own
  logic              aw_pend;
  logic [XLEN-1:0]   aw_skid_addr;
  logic              w_pend;
  logic [XLEN-1:0]   w_skid_data;
  logic [STRB_W-1:0] w_skid_strb;

  logic              req_fire;
  logic              aw_free;
  logic              w_free;
  logic              b_fire;
  logic              wres_free;

  assign req_fire  = wreq_valid & wreq_ready;
  assign aw_free   = ~awvalid | awready;
  assign w_free    = ~wvalid | wready;
  assign b_fire    = bvalid & bready;
  assign wres_free = ~wres_valid | wres_ready;

  // no new request while either skid holds something
  assign wreq_ready = ~aw_pend & ~w_pend;

  always_comb begin
    case (wfunc)
      st_b:    strb_base = {{(STRB_W-1){1'b0}}, 1'b1};
      st_h:    strb_base = {{(STRB_W-2){1'b0}}, 2'b11};
      default: strb_base = {STRB_W{1'b1}};
    endcase
  end

  // lanes past the top of the word fall off
  assign strb_lane = strb_base << waddr[OFF_W-1:0];
  assign data_lane = wdata << {waddr[OFF_W-1:0], 3'b000};

  always_ff @(posedge clk) begin
    if (rstn) begin
      awvalid    <= 1'b0;
      wvalid     <= 1'b0;
      aw_pend    <= 1'b0;
      w_pend     <= 1'b0;
      bready     <= 1'b1;
      wres_valid <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        awvalid <= 1'b0;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
      end

      if (aw_pend && aw_free) begin
        awvalid <= 1'b1;
        awaddr  <= aw_skid_addr;
        aw_pend <= 1'b0;
      end
      if (w_pend && w_free) begin
        wvalid    <= 1'b1;
        wdata_bus <= w_skid_data;
        wstrb     <= w_skid_strb;
        w_pend    <= 1'b0;
      end

      if (req_fire) begin
        if (aw_free) begin
          awvalid <= 1'b1;
          awaddr  <= waddr;
        end else begin
          aw_pend      <= 1'b1;
          aw_skid_addr <= waddr;
        end
        if (w_free) begin
          wvalid    <= 1'b1;
          wdata_bus <= data_lane;
          wstrb     <= strb_lane;
        end else begin
          w_pend      <= 1'b1;
          w_skid_data <= data_lane;
          w_skid_strb <= strb_lane;
        end
      end

      // write responses
      if (wres_valid && wres_ready) begin
        wres_valid <= 1'b0;
      end
      if (b_fire) begin
        if (wres_free) begin
          wres_valid <= 1'b1;
        end else begin
          bready <= 1'b0;
        end
      end
      if (!bready && wres_free) begin
        wres_valid <= 1'b1;
        bready     <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
`default_nettype none

module lsu_top #(
  parameter int mem_words = 256
) (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     rreq_valid,
  output logic                     rreq_ready,
  input  logic [lsu_pkg::XLEN-1:0] raddr,
  input  lsu_pkg::load_func_e      rfunc,
  output logic                     rres_valid,
  input  logic                     rres_ready,
  output logic [lsu_pkg::XLEN-1:0] rdata,
  input  logic                     wreq_valid,
  output logic                     wreq_ready,
  input  logic [lsu_pkg::XLEN-1:0] waddr,
  input  lsu_pkg::store_func_e     wfunc,
  input  logic [lsu_pkg::XLEN-1:0] wdata,
  output logic                     wres_valid,
  input  logic                     wres_ready,
  input  logic                     mem_hold
);
  import lsu_pkg::*;

  // read bus
  logic [XLEN-1:0]   araddr;
  logic              arvalid;
  logic              arready;
  logic [XLEN-1:0]   ram_rdata;
  logic              rvalid;
  logic              rready;

  // write bus
  logic [XLEN-1:0]   awaddr;
  logic              awvalid;
  logic              awready;
  logic [XLEN-1:0]   wdata_bus;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  logic              bvalid;
  logic              bready;

  lsu_load load_i (
    .clk        (clk),
    .rstn       (rstn),
    .raddr      (raddr),
    .rfunc      (rfunc),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .rdata      (rdata),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .bus_rdata  (ram_rdata),
    .rvalid     (rvalid),
    .rready     (rready)
  );

  lsu_store store_i (
    .clk        (clk),
    .rstn       (rstn),
    .waddr      (waddr),
    .wdata      (wdata),
    .wfunc      (wfunc),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata_bus  (wdata_bus),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready)
  );

  axi_lite_ram #(
    .mem_words (mem_words)
  ) ram_i (
    .clk      (clk),
    .rstn     (rstn),
    .mem_hold (mem_hold),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (ram_rdata),
    .rvalid   (rvalid),
    .rready   (rready),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata_bus),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bvalid   (bvalid),
    .bready   (bready)
  );

endmodule

`default_nettype wire

// ==== lsu_top.f ====
hdl/lsu_pkg.sv
hdl/lsu_load.sv
hdl/lsu_store.sv
hdl/axi_lite_ram.sv
hdl/lsu_top.sv
dv/lsu_top_tb.sv
